//--- hw/cache_pkg.sv
package cache_pkg;

    // processor word and cache line geometry
    localparam int WORD_W         = 32;
    localparam int LINE_W         = 128;
    localparam int WORDS_PER_LINE = 4;

    // two-way, four sets
    localparam int NUM_SETS = 4;
    localparam int NUM_WAYS = 2;

    // word address split
    localparam int TAG_W    = 26;
    localparam int INDEX_W  = 2;
    localparam int OFFSET_W = 2;

    localparam int ADDR_W      = TAG_W + INDEX_W + OFFSET_W;
    localparam int LINE_ADDR_W = TAG_W + INDEX_W;

    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } proc_addr_t;

    // memory side request, held until mem_ready
    typedef struct packed {
        logic                   read;
        logic                   write;
        logic [LINE_ADDR_W-1:0] addr;
        logic [LINE_W-1:0]      wdata;
    } mem_req_t;

    // one command to all ways, set index comes from the address
    typedef struct packed {
        logic [NUM_WAYS-1:0] en;
        logic                word_wr;
        logic [OFFSET_W-1:0] offset;
        logic [WORD_W-1:0]   wdata;
        logic                fill;
        logic [TAG_W-1:0]    tag;
        logic [LINE_W-1:0]   line;
    } way_cmd_t;

    // what a way reports for the indexed set
    typedef struct packed {
        logic              hit;
        logic              valid;
        logic              dirty;
        logic [TAG_W-1:0]  tag;
        logic [LINE_W-1:0] line;
    } way_status_t;

    typedef enum logic [1:0] {
        S_IDLE,
        S_WRITE_BACK,
        S_ALLOCATE
    } cache_state_e;

endpackage

//--- hw/cache_way.sv
module cache_way #(
    parameter int WAY_ID = 0
) (
    input  logic                   clk,
    input  logic                   proc_reset,
    input  cache_pkg::proc_addr_t  addr,
    input  cache_pkg::way_cmd_t    cmd,
    output cache_pkg::way_status_t status
);
    import cache_pkg::*;

    logic [TAG_W-1:0]  tag_q  [NUM_SETS];
    logic [LINE_W-1:0] line_q [NUM_SETS];
    logic [NUM_SETS-1:0] valid_q;
    logic [NUM_SETS-1:0] dirty_q;

    logic              sel;
    logic              we;
    logic [LINE_W-1:0] base_line;
    logic [LINE_W-1:0] new_line;

    // command addressed to this way
    assign sel = cmd.en[WAY_ID];
    assign we  = sel & (cmd.fill | cmd.word_wr);

    // report the indexed set
    assign status.valid = valid_q[addr.index];
    assign status.dirty = dirty_q[addr.index];
    assign status.tag   = tag_q[addr.index];
    assign status.line  = line_q[addr.index];
    assign status.hit   = valid_q[addr.index] & (tag_q[addr.index] == addr.tag);

    // fill line or stored line, then merge the processor word
    always_comb begin
        base_line = cmd.fill ? cmd.line : line_q[addr.index];
        new_line  = base_line;
        if (cmd.word_wr) begin
            new_line[cmd.offset*WORD_W +: WORD_W] = cmd.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            line_q[addr.index] <= new_line;
            if (cmd.fill) begin
                tag_q[addr.index] <= cmd.tag;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (proc_reset) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (we) begin
            if (cmd.fill) begin
                valid_q[addr.index] <= 1'b1;
                // a write-allocate leaves the line dirty
                dirty_q[addr.index] <= cmd.word_wr;
            end else begin
                dirty_q[addr.index] <= 1'b1;
            end
        end
    end

endmodule

//--- hw/way_select.sv
module way_select (
    input  logic                          clk,
    input  logic                          proc_reset,
    input  cache_pkg::proc_addr_t         addr,
    input  cache_pkg::way_status_t        way_status [cache_pkg::NUM_WAYS],
    input  logic                          touch,
    input  logic                          touch_way,
    output logic                          hit,
    output logic                          hit_way,
    output logic                          victim_way,
    output logic [cache_pkg::WORD_W-1:0]  hit_word
);
    import cache_pkg::*;

    // one bit per set, points at the way to replace next
    logic [NUM_SETS-1:0] lru_q;

    logic [LINE_W-1:0] hit_line;

    // way 0 wins if both report a hit
    assign hit     = way_status[0].hit | way_status[1].hit;
    assign hit_way = ~way_status[0].hit;

    assign hit_line = way_status[hit_way].line;
    assign hit_word = hit_line[addr.offset*WORD_W +: WORD_W];

    // invalid ways first, then lru
    always_comb begin
        if (!way_status[0].valid) begin
            victim_way = 1'b0;
        end else if (!way_status[1].valid) begin
            victim_way = 1'b1;
        end else begin
            victim_way = lru_q[addr.index];
        end
    end

    always_ff @(posedge clk) begin
        if (proc_reset) begin
            lru_q <= '0;
        end else if (touch) begin
            // used way becomes most recent
            lru_q[addr.index] <= ~touch_way;
        end
    end

endmodule

//--- hw/miss_controller.sv
module miss_controller (
    input  logic                          clk,
    input  logic                          proc_reset,
    input  logic                          proc_read,
    input  logic                          proc_write,
    input  cache_pkg::proc_addr_t         addr,
    input  logic [cache_pkg::WORD_W-1:0]  proc_wdata,
    input  cache_pkg::way_status_t        way_status [cache_pkg::NUM_WAYS],
    input  logic                          hit,
    input  logic                          hit_way,
    input  logic                          victim_way,
    input  logic [cache_pkg::LINE_W-1:0]  mem_rdata,
    input  logic                          mem_ready,
    output cache_pkg::mem_req_t           mem_req,
    output cache_pkg::way_cmd_t           cmd,
    output logic                          touch,
    output logic                          touch_way,
    output logic                          proc_stall,
    output logic                          fill_valid,
    output logic [cache_pkg::WORD_W-1:0]  fill_word
);
    import cache_pkg::*;

    cache_state_e state_q;
    cache_state_e state_d;

    logic              mem_ready_q;
    logic [LINE_W-1:0] mem_rdata_q;

    logic        req;
    way_status_t victim;

    assign req    = proc_read | proc_write;
    assign victim = way_status[victim_way];

    // word the refill brings for the current offset
    assign fill_word = mem_rdata_q[addr.offset*WORD_W +: WORD_W];

    always_comb begin
        state_d    = state_q;
        mem_req    = '0;
        cmd        = '0;
        touch      = 1'b0;
        touch_way  = hit_way;
        proc_stall = 1'b0;
        fill_valid = 1'b0;

        // write data and offset are the same for hit and fill
        cmd.offset = addr.offset;
        cmd.wdata  = proc_wdata;

        case (state_q)
            S_IDLE: begin
                if (req && hit) begin
                    cmd.en[hit_way] = 1'b1;
                    cmd.word_wr     = proc_write;
                    touch           = 1'b1;
                end else if (req) begin
                    proc_stall = 1'b1;
                    if (victim.valid && victim.dirty) begin
                        mem_req.write = 1'b1;
                        mem_req.addr  = {victim.tag, addr.index};
                        mem_req.wdata = victim.line;
                        state_d       = S_WRITE_BACK;
                    end else begin
                        mem_req.read = 1'b1;
                        mem_req.addr = {addr.tag, addr.index};
                        state_d      = S_ALLOCATE;
                    end
                end
            end

            S_WRITE_BACK: begin
                proc_stall = 1'b1;
                if (mem_ready_q) begin
                    // victim written, fetch the requested line
                    mem_req.read = 1'b1;
                    mem_req.addr = {addr.tag, addr.index};
                    state_d      = S_ALLOCATE;
                end else begin
                    mem_req.write = 1'b1;
                    mem_req.addr  = {victim.tag, addr.index};
                    mem_req.wdata = victim.line;
                end
            end

            S_ALLOCATE: begin
                proc_stall = 1'b1;
                if (mem_ready_q) begin
                    // refill victim, merging a pending write
                    cmd.en[victim_way] = 1'b1;
                    cmd.fill           = 1'b1;
                    cmd.tag            = addr.tag;
                    cmd.line           = mem_rdata_q;
                    cmd.word_wr        = proc_write;
                    touch              = 1'b1;
                    touch_way          = victim_way;
                    fill_valid         = 1'b1;
                    state_d            = S_IDLE;
                end else begin
                    mem_req.read = 1'b1;
                    mem_req.addr = {addr.tag, addr.index};
                end
            end

            default: begin
                state_d = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (proc_reset) begin
            state_q     <= S_IDLE;
            mem_ready_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            mem_ready_q <= mem_ready;
        end
    end

    // response data used one cycle after the ready pulse
    always_ff @(posedge clk) begin
        mem_rdata_q <= mem_rdata;
    end

endmodule

//--- hw/data_cache.sv
module data_cache (
    input  logic                               clk,
    input  logic                               proc_reset,
    input  logic                               proc_read,
    input  logic                               proc_write,
    input  logic [cache_pkg::ADDR_W-1:0]       proc_addr,
    output logic [cache_pkg::WORD_W-1:0]       proc_rdata,
    input  logic [cache_pkg::WORD_W-1:0]       proc_wdata,
    output logic                               proc_stall,
    output logic                               mem_read,
    output logic                               mem_write,
    output logic [cache_pkg::LINE_ADDR_W-1:0]  mem_addr,
    input  logic [cache_pkg::LINE_W-1:0]       mem_rdata,
    output logic [cache_pkg::LINE_W-1:0]       mem_wdata,
    input  logic                               mem_ready
);
    import cache_pkg::*;

    proc_addr_t  addr;
    mem_req_t    mem_req;
    way_cmd_t    cmd;
    way_status_t way_status [NUM_WAYS];

    logic              hit;
    logic              hit_way;
    logic              victim_way;
    logic              touch;
    logic              touch_way;
    logic              fill_valid;
    logic [WORD_W-1:0] fill_word;
    logic [WORD_W-1:0] hit_word;

    assign addr = proc_addr;

    assign mem_read  = mem_req.read;
    assign mem_write = mem_req.write;
    assign mem_addr  = mem_req.addr;
    assign mem_wdata = mem_req.wdata;

    // refill word during the fill cycle, stored word otherwise
    assign proc_rdata = fill_valid ? fill_word : hit_word;

    miss_controller u_ctrl (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_read  (proc_read),
        .proc_write (proc_write),
        .addr       (addr),
        .proc_wdata (proc_wdata),
        .way_status (way_status),
        .hit        (hit),
        .hit_way    (hit_way),
        .victim_way (victim_way),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready),
        .mem_req    (mem_req),
        .cmd        (cmd),
        .touch      (touch),
        .touch_way  (touch_way),
        .proc_stall (proc_stall),
        .fill_valid (fill_valid),
        .fill_word  (fill_word)
    );

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        cache_way #(
            .WAY_ID (w)
        ) u_way (
            .clk        (clk),
            .proc_reset (proc_reset),
            .addr       (addr),
            .cmd        (cmd),
            .status     (way_status[w])
        );
    end

    way_select u_sel (
        .clk        (clk),
        .proc_reset (proc_reset),
        .addr       (addr),
        .way_status (way_status),
        .touch      (touch),
        .touch_way  (touch_way),
        .hit        (hit),
        .hit_way    (hit_way),
        .victim_way (victim_way),
        .hit_word   (hit_word)
    );

endmodule

//--- tests/tb_clock.sv
module tb_clock #(
    parameter int PERIOD = 10
) (
    output logic clk
);

    // free running, starts low
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

//--- tests/data_cache_tb.sv
module data_cache_tb;
    import cache_pkg::*;

    localparam int NUM_REQ        = 400;
    localparam int CYCLES_PER_REQ = 20;
    localparam int CLK_PERIOD     = 10;
    localparam int RESET_CYCLES   = 10;

    logic                   clk;
    logic                   proc_reset;
    logic                   proc_read;
    logic                   proc_write;
    logic [ADDR_W-1:0]      proc_addr;
    logic [WORD_W-1:0]      proc_rdata;
    logic [WORD_W-1:0]      proc_wdata;
    logic                   proc_stall;
    logic                   mem_read;
    logic                   mem_write;
    logic [LINE_ADDR_W-1:0] mem_addr;
    logic [LINE_W-1:0]      mem_rdata;
    logic [LINE_W-1:0]      mem_wdata;
    logic                   mem_ready;

    // backing store and last written word per address
    logic [LINE_W-1:0] mem_lines [logic [LINE_ADDR_W-1:0]];
    logic [WORD_W-1:0] word_model [logic [ADDR_W-1:0]];

    // mirror of cache tags and replacement state
    logic [TAG_W-1:0] m_tag   [NUM_SETS][NUM_WAYS];
    logic             m_valid [NUM_SETS][NUM_WAYS];
    logic             m_dirty [NUM_SETS][NUM_WAYS];
    logic             m_lru   [NUM_SETS];

    logic [TAG_W-1:0] tag_pool [5];

    tb_clock #(.PERIOD(CLK_PERIOD)) u_clock (.clk(clk));

    data_cache DUT (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_read  (proc_read),
        .proc_write (proc_write),
        .proc_addr  (proc_addr),
        .proc_rdata (proc_rdata),
        .proc_wdata (proc_wdata),
        .proc_stall (proc_stall),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_rdata  (mem_rdata),
        .mem_wdata  (mem_wdata),
        .mem_ready  (mem_ready)
    );

    task automatic fail_check(input string msg);
        $display("CHECK FAILED at time %0t: %s", $time, msg);
        $display("Checks failed");
        $fatal(1);
    endtask

    // power-up memory contents mix every address bit
    function automatic logic [WORD_W-1:0] init_word(input logic [ADDR_W-1:0] wa);
        return {2'b10, wa} ^ {wa[15:0], wa[29:14]};
    endfunction

    function automatic logic [WORD_W-1:0] expected_word(input logic [ADDR_W-1:0] wa);
        if (word_model.exists(wa)) begin
            return word_model[wa];
        end
        return init_word(wa);
    endfunction

    function automatic logic [LINE_W-1:0] expected_line(input logic [LINE_ADDR_W-1:0] la);
        logic [LINE_W-1:0] line;
        int o;
        for (o = 0; o < WORDS_PER_LINE; o++) begin
            line[o*WORD_W +: WORD_W] = expected_word({la, 2'(o)});
        end
        return line;
    endfunction

    function automatic logic [LINE_W-1:0] memory_line(input logic [LINE_ADDR_W-1:0] la);
        logic [LINE_W-1:0] line;
        int o;
        if (mem_lines.exists(la)) begin
            return mem_lines[la];
        end
        for (o = 0; o < WORDS_PER_LINE; o++) begin
            line[o*WORD_W +: WORD_W] = init_word({la, 2'(o)});
        end
        return line;
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            proc_read  <= 1'b0;
            proc_write <= 1'b0;
        end
    endtask

    // one processor request checked against the mirror until stall drops
    task automatic do_request(input logic is_write, input proc_addr_t a,
                              input logic [WORD_W-1:0] wdata, output logic was_hit,
                              output logic [LINE_ADDR_W-1:0] first_addr);
        logic                   exp_hit;
        logic                   hw;
        logic                   vw;
        logic                   vdirty;
        logic                   saw_read;
        logic [LINE_ADDR_W-1:0] req_line;
        logic [LINE_ADDR_W-1:0] vic_line;
        logic [LINE_W-1:0]      vic_data;
        logic [WORD_W-1:0]      exp_rdata;
        logic [WORD_W-1:0]      stall_rdata;
        req_line  = {a.tag, a.index};
        exp_rdata = expected_word(a);
        exp_hit   = 1'b0;
        hw        = 1'b0;
        if (m_valid[a.index][0] && m_tag[a.index][0] == a.tag) begin
            exp_hit = 1'b1;
        end else if (m_valid[a.index][1] && m_tag[a.index][1] == a.tag) begin
            exp_hit = 1'b1;
            hw      = 1'b1;
        end
        // victim prefers an invalid way over lru
        if (!m_valid[a.index][0]) begin
            vw = 1'b0;
        end else if (!m_valid[a.index][1]) begin
            vw = 1'b1;
        end else begin
            vw = m_lru[a.index];
        end
        vdirty   = m_valid[a.index][vw] && m_dirty[a.index][vw];
        vic_line = {m_tag[a.index][vw], a.index};
        vic_data = expected_line(vic_line);

        @(posedge clk);
        proc_read  <= !is_write;
        proc_write <= is_write;
        proc_addr  <= a;
        proc_wdata <= wdata;

        @(negedge clk);
        was_hit    = !proc_stall;
        first_addr = mem_addr;
        assert (proc_stall == !exp_hit)
            else fail_check($sformatf("stall %0b, expected hit %0b", proc_stall, exp_hit));
        if (exp_hit) begin
            assert (!mem_read && !mem_write) else fail_check("memory request on a hit");
        end else if (vdirty) begin
            assert (mem_write && !mem_read && mem_addr == vic_line)
                else fail_check($sformatf("write-back addr %h, expected %h", mem_addr, vic_line));
            assert (mem_wdata == vic_data)
                else fail_check($sformatf("write-back data %h, expected %h", mem_wdata, vic_data));
        end else begin
            assert (mem_read && !mem_write && mem_addr == req_line)
                else fail_check($sformatf("refill addr %h, expected %h", mem_addr, req_line));
        end

        saw_read = mem_read;
        while (proc_stall) begin
            // the last stalled cycle is the refill
            stall_rdata = proc_rdata;
            @(negedge clk);
            if (mem_read) begin
                assert (mem_addr == req_line)
                    else fail_check($sformatf("read addr %h, expected %h", mem_addr, req_line));
                saw_read = 1'b1;
            end
            if (mem_write) begin
                assert (mem_addr == vic_line)
                    else fail_check($sformatf("write addr %h, expected %h", mem_addr, vic_line));
            end
        end

        // request completes as a hit
        assert (!mem_read && !mem_write) else fail_check("memory request as stall fell");
        assert (exp_hit || saw_read) else fail_check("miss ended without a refill read");
        if (!is_write) begin
            assert (proc_rdata == exp_rdata)
                else fail_check($sformatf("read %h at %h, expected %h", proc_rdata, a, exp_rdata));
        end
        if (!exp_hit && !is_write) begin
            assert (stall_rdata == exp_rdata)
                else fail_check($sformatf("refill word %h at %h, expected %h",
                                          stall_rdata, a, exp_rdata));
        end

        if (exp_hit) begin
            m_lru[a.index] = !hw;
            if (is_write) begin
                m_dirty[a.index][hw] = 1'b1;
            end
        end else begin
            m_tag[a.index][vw]   = a.tag;
            m_valid[a.index][vw] = 1'b1;
            m_dirty[a.index][vw] = is_write;
            m_lru[a.index]       = !vw;
        end
        if (is_write) begin
            word_model[a] = wdata;
        end
    endtask

    // memory responder serves one request at a time
    initial begin
        logic                   is_wr;
        logic [LINE_ADDR_W-1:0] laddr;
        logic [LINE_W-1:0]      wline;
        mem_ready = 1'b0;
        mem_rdata = '0;
        forever begin
            @(negedge clk);
            if (!proc_reset && (mem_read || mem_write)) begin
                is_wr = mem_write;
                laddr = mem_addr;
                wline = mem_wdata;
                repeat ($urandom_range(1, 4)) @(posedge clk);
                mem_ready <= 1'b1;
                if (is_wr) begin
                    mem_lines[laddr] = wline;
                end else begin
                    mem_rdata <= memory_line(laddr);
                end
                @(posedge clk);
                mem_ready <= 1'b0;
                // controller acts on the registered ready here
                @(posedge clk);
            end
        end
    end

    initial begin
        #((NUM_REQ + 20) * CYCLES_PER_REQ * CLK_PERIOD);
        $display("watchdog expired before the requests finished");
        $display("Checks failed");
        $fatal(1);
    end

    initial begin
        proc_addr_t             a;
        logic                   is_wr;
        logic                   hit_flag;
        logic [LINE_ADDR_W-1:0] first;
        logic [WORD_W-1:0]      tmp;
        int                     i;
        int                     s;
        proc_reset = 1'b1;
        proc_read  = 1'b0;
        proc_write = 1'b0;
        proc_addr  = '0;
        proc_wdata = '0;
        void'($urandom(32'h6f1d784f));

        for (s = 0; s < NUM_SETS; s++) begin
            m_tag[s][0]   = '0;
            m_tag[s][1]   = '0;
            m_valid[s][0] = 1'b0;
            m_valid[s][1] = 1'b0;
            m_dirty[s][0] = 1'b0;
            m_dirty[s][1] = 1'b0;
            m_lru[s]      = 1'b0;
        end
        // low bits keep the five tags distinct
        for (i = 0; i < 5; i++) begin
            tmp         = $urandom();
            tag_pool[i] = {tmp[22:0], 3'(i)};
        end

        repeat (RESET_CYCLES) @(posedge clk);
        proc_reset <= 1'b0;
        @(negedge clk);
        assert (!proc_stall && !mem_read && !mem_write)
            else fail_check("stall or memory request active after reset");

        // lru order in one set with A, B and A again before C evicts B
        a.index  = 2'd2;
        a.offset = 2'd1;
        a.tag    = tag_pool[0];
        do_request(1'b1, a, 32'h1111_0001, hit_flag, first);
        a.tag = tag_pool[1];
        do_request(1'b1, a, 32'h2222_0002, hit_flag, first);
        a.tag = tag_pool[0];
        do_request(1'b0, a, '0, hit_flag, first);
        assert (hit_flag) else fail_check("first tag missed after reuse");
        a.tag = tag_pool[2];
        do_request(1'b0, a, '0, hit_flag, first);
        assert (!hit_flag && first == {tag_pool[1], 2'd2})
            else fail_check($sformatf("third tag evicted line %h, not the second tag", first));
        a.tag = tag_pool[1];
        do_request(1'b0, a, '0, hit_flag, first);
        assert (!hit_flag) else fail_check("second tag still resident after eviction");
        assert (first == {tag_pool[0], 2'd2})
            else fail_check($sformatf("second tag refill evicted %h, not the first", first));

        for (i = 0; i < NUM_REQ; i++) begin
            a.tag    = tag_pool[$urandom_range(0, 4)];
            a.index  = INDEX_W'($urandom_range(0, NUM_SETS - 1));
            a.offset = OFFSET_W'($urandom_range(0, WORDS_PER_LINE - 1));
            is_wr    = 1'($urandom_range(0, 1));
            tmp      = $urandom();
            do_request(is_wr, a, tmp, hit_flag, first);
            if ($urandom_range(0, 3) == 0) begin
                idle_cycles($urandom_range(1, 2));
            end
        end
        idle_cycles(1);

        $display("All checks passed");
        $finish;
    end

endmodule

//--- vlog.f
hw/cache_pkg.sv
hw/cache_way.sv
hw/way_select.sv
hw/miss_controller.sv
hw/data_cache.sv
tests/tb_clock.sv
tests/data_cache_tb.sv

//--- Bender.yml
package:
  name: data_cache

sources:
  - files:
      - hw/cache_pkg.sv
      - hw/cache_way.sv
      - hw/way_select.sv
      - hw/miss_controller.sv
      - hw/data_cache.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/data_cache_tb.sv
